// ==== cal_pkg.sv ====
`default_nettype none

// Camera-side definitions for the calibration table path
package cal_pkg;

    // Brightness sample from the frame buffer
    localparam int LUMA_WIDTH = 16;

    // One frame-buffer pixel as it streams past
    typedef struct packed {
        logic                  valid; // Sample present this cycle
        logic [LUMA_WIDTH-1:0] luma;  // Brightness
    } frame_pixel_t;

    // 17 bits in all
    localparam int FRAME_PIXEL_WIDTH = $bits(frame_pixel_t);

endpackage

`default_nettype wire

// ==== cal_table_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

// Calibration table, one entry per camera pixel
// Port a is read/write for the accumulator, port b read-only for display
module cal_table_ram #(
    parameter int NUM_PIXELS = 64,
    parameter int LED_ADDRESS_WIDTH = 10,
    localparam int ADDR_W = (NUM_PIXELS > 1) ? $clog2(NUM_PIXELS) : 1,
    localparam int ENTRY_W = LED_ADDRESS_WIDTH + 1
)(
    input  wire                clk,
    input  wire   [ADDR_W-1:0] addr_a,
    input  wire   [ADDR_W-1:0] waddr_a,  // Write side of port a
    input  wire                we_a,
    input  wire  [ENTRY_W-1:0] wdata_a,
    output logic [ENTRY_W-1:0] rdata_a,  // Two cycles after addr_a
    input  wire   [ADDR_W-1:0] addr_b,
    output logic [ENTRY_W-1:0] rdata_b   // Two cycles after addr_b
);

    logic [ENTRY_W-1:0] mem [NUM_PIXELS];
    logic [ENTRY_W-1:0] rd_a_q;          // First output stage, port a
    logic [ENTRY_W-1:0] rd_b_q;          // First output stage, port b

    // Table starts empty at configuration
    initial begin
        for (int i = 0; i < NUM_PIXELS; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (we_a) begin
            mem[waddr_a] <= wdata_a;
        end
        rd_a_q <= mem[addr_a];           // Read-first, old contents
        rdata_a <= rd_a_q;
    end

    // Display port sees a same-cycle write from port a
    always_ff @(posedge clk) begin
        if (we_a && (waddr_a == addr_b)) begin
            rd_b_q <= wdata_a;
        end else begin
            rd_b_q <= mem[addr_b];
        end
        rdata_b <= rd_b_q;
    end

endmodule

`default_nettype wire

// ==== calibration_manager.sv ====
`timescale 1ns/100ps
`default_nettype none

// Calibration subsystem top: bit-plane shower plus pixel-to-LED table
module calibration_manager #(
    parameter int NUM_LEDS = 50,
    parameter int LED_ADDRESS_WIDTH = 10,
    parameter int NUM_PIXELS = 360 * 180,
    parameter logic [cal_pkg::LUMA_WIDTH-1:0] LUMA_THRESHOLD = 16'hFFF0,
    parameter int CREDIT_DEPTH = 8,
    localparam int ADDR_W = (NUM_PIXELS > 1) ? $clog2(NUM_PIXELS) : 1
)(
    input  wire                          clk,
    input  wire                          arst_n,
    input  wire                          increment_id,     // User steps the bit-plane
    input  wire                          calibration_on,   // Enables table writes
    input  wire                          led_credit,       // From strand driver
    output led_pkg::rgb_t                led_color,
    output logic                         color_valid,
    output logic                         displayed_frame_valid,
    input  wire             [ADDR_W-1:0] pixel_addr,       // Frame buffer stream
    input  cal_pkg::frame_pixel_t        pixel,
    input  wire             [ADDR_W-1:0] cal_read_addr,    // Display side lookup
    output logic   [LED_ADDRESS_WIDTH:0] cal_read_data     // Two cycles later
);

    logic          [ADDR_W-1:0] acc_addr;   // Accumulator port a
    logic          [ADDR_W-1:0] acc_waddr;
    logic                       acc_we;
    logic [LED_ADDRESS_WIDTH:0] acc_wdata;
    logic [LED_ADDRESS_WIDTH:0] acc_rdata;

    id_shower #(
        .NUM_LEDS          (NUM_LEDS),
        .LED_ADDRESS_WIDTH (LED_ADDRESS_WIDTH),
        .CREDIT_DEPTH      (CREDIT_DEPTH)
    ) u_id_shower (
        .clk                   (clk),
        .arst_n                (arst_n),
        .increment_id          (increment_id),
        .led_credit            (led_credit),
        .led_color             (led_color),
        .color_valid           (color_valid),
        .displayed_frame_valid (displayed_frame_valid)
    );

    pixel_accumulator #(
        .NUM_PIXELS        (NUM_PIXELS),
        .LED_ADDRESS_WIDTH (LED_ADDRESS_WIDTH),
        .LUMA_THRESHOLD    (LUMA_THRESHOLD)
    ) u_pixel_accumulator (
        .clk            (clk),
        .arst_n         (arst_n),
        .calibration_on (calibration_on),
        .pixel_addr     (pixel_addr),
        .pixel          (pixel),
        .ram_addr       (acc_addr),
        .ram_waddr      (acc_waddr),
        .ram_rdata      (acc_rdata),
        .ram_we         (acc_we),
        .ram_wdata      (acc_wdata)
    );

    // Port a internal RMW, port b for the display
    cal_table_ram #(
        .NUM_PIXELS        (NUM_PIXELS),
        .LED_ADDRESS_WIDTH (LED_ADDRESS_WIDTH)
    ) u_cal_table_ram (
        .clk     (clk),
        .addr_a  (acc_addr),
        .waddr_a (acc_waddr),
        .we_a    (acc_we),
        .wdata_a (acc_wdata),
        .rdata_a (acc_rdata),
        .addr_b  (cal_read_addr),
        .rdata_b (cal_read_data)
    );

endmodule

`default_nettype wire

// ==== id_shower.sv ====
`timescale 1ns/100ps
`default_nettype none

// Shows one bit-plane of LED indices per frame, paced by driver credits
module id_shower #(
    parameter int NUM_LEDS = 50,
    parameter int LED_ADDRESS_WIDTH = 10,
    parameter int CREDIT_DEPTH = 8
)(
    input  wire            clk,
    input  wire            arst_n,
    input  wire            increment_id,          // Advance bit-plane from next frame
    input  wire            led_credit,            // One pulse, one colour word
    output led_pkg::rgb_t  led_color,
    output logic           color_valid,
    output logic           displayed_frame_valid  // Last LED of the frame
);

    import led_pkg::*;

    localparam int IDX_W = LED_ADDRESS_WIDTH + 1;
    localparam int BIT_W = (LED_ADDRESS_WIDTH > 0) ? $clog2(LED_ADDRESS_WIDTH + 1) : 1;
    localparam int CNT_W = $clog2(CREDIT_DEPTH + 2); // Room for one overflow

    shower_state_e    state;
    logic [CNT_W-1:0] credit_cnt;   // Stored credits
    logic [IDX_W-1:0] led_idx;      // LED being sent
    logic [BIT_W-1:0] pending_bit;  // Follows increment_id
    logic [BIT_W-1:0] active_bit;   // Plane shown this frame
    logic [BIT_W-1:0] pending_next;
    logic             last_led;
    logic             lit;

    // Plane index wraps after LED_ADDRESS_WIDTH+1 planes
    always_comb begin
        if (pending_bit == BIT_W'(LED_ADDRESS_WIDTH)) begin
            pending_next = '0;
        end else begin
            pending_next = pending_bit + 1'b1;
        end
    end

    assign last_led = (led_idx == IDX_W'(NUM_LEDS - 1));
    assign lit      = led_idx[active_bit];

    // Zero latency from a stored credit
    assign color_valid           = (state == SH_SEND) && (credit_cnt != '0);
    assign displayed_frame_valid = color_valid && last_led;

    assign led_color.green = {COLOR_WIDTH{lit}};
    assign led_color.red   = {COLOR_WIDTH{lit}};
    assign led_color.blue  = {COLOR_WIDTH{lit}};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= SH_IDLE;
            credit_cnt  <= '0;
            led_idx     <= '0;
            pending_bit <= '0;
            active_bit  <= '0;
        end else begin
            // Credit in and colour out may share a cycle
            credit_cnt <= credit_cnt + CNT_W'(led_credit) - CNT_W'(color_valid);

            if (increment_id) begin
                pending_bit <= pending_next;
            end

            case (state)
                SH_IDLE: begin
                    if ((credit_cnt != '0) || led_credit) begin
                        state <= SH_SEND;
                    end
                end
                SH_SEND: begin
                    // No credit, hold position
                    if (color_valid) begin
                        if (last_led) begin
                            led_idx <= '0;
                            state   <= SH_DONE;
                        end else begin
                            led_idx <= led_idx + 1'b1;
                        end
                    end
                end
                SH_DONE: begin
                    active_bit <= pending_bit; // Pulse in this cycle waits a frame
                    state      <= SH_IDLE;
                end
                default: state <= SH_IDLE;
            endcase
        end
    end

    // Driver must not hand out more credits than it was sized for
    a_credit_bound: assert property (
        @(posedge clk) disable iff (!arst_n)
        credit_cnt <= CNT_W'(CREDIT_DEPTH)
    );

    // A colour word starts only after some credit reached us
    a_color_has_credit: assert property (
        @(posedge clk) disable iff (!arst_n)
        $rose(color_valid) |-> ($past(led_credit) || $past(credit_cnt != '0))
    );

endmodule

`default_nettype wire

// ==== led_pkg.sv ====
`default_nettype none

// Strand-side definitions for the ID shower
package led_pkg;

    localparam int COLOR_WIDTH = 8; // One channel

    // GRB order, as WS281x-style drivers shift it out
    typedef struct packed {
        logic [COLOR_WIDTH-1:0] green;
        logic [COLOR_WIDTH-1:0] red;
        logic [COLOR_WIDTH-1:0] blue;
    } rgb_t;

    // ID shower states
    typedef enum logic [1:0] {
        SH_IDLE = 2'd0, // Wait for first credit of a frame
        SH_SEND = 2'd1, // Stream colours
        SH_DONE = 2'd2  // Latch bit index for next frame
    } shower_state_e;

endpackage

`default_nettype wire

// ==== list.f ====
cal_pkg.sv
led_pkg.sv
cal_table_ram.sv
id_shower.sv
pixel_accumulator.sv
calibration_manager.sv
tb_calibration_manager.sv

// ==== pixel_accumulator.sv ====
`timescale 1ns/100ps
`default_nettype none

// Thresholds streamed pixels and shifts the lit bit into each table entry
module pixel_accumulator #(
    parameter int NUM_PIXELS = 64,
    parameter int LED_ADDRESS_WIDTH = 10,
    parameter logic [cal_pkg::LUMA_WIDTH-1:0] LUMA_THRESHOLD = 16'hFFF0,
    localparam int ADDR_W = (NUM_PIXELS > 1) ? $clog2(NUM_PIXELS) : 1,
    localparam int ENTRY_W = LED_ADDRESS_WIDTH + 1
)(
    input  wire                   clk,
    input  wire                   arst_n,
    input  wire                   calibration_on,
    input  wire      [ADDR_W-1:0] pixel_addr,
    input  cal_pkg::frame_pixel_t pixel,
    output logic     [ADDR_W-1:0] ram_addr,
    output logic     [ADDR_W-1:0] ram_waddr,  // Address of the stage-2 write
    input  wire     [ENTRY_W-1:0] ram_rdata,  // Two cycles after ram_addr
    output logic                  ram_we,
    output logic    [ENTRY_W-1:0] ram_wdata
);

    // One pixel moving down the pipe
    typedef struct packed {
        logic              valid;  // Will write when it reaches stage 2
        logic [ADDR_W-1:0] addr;
        logic              lit;
    } stage_t;

    // A write already sent to the RAM
    typedef struct packed {
        logic               valid;
        logic [ADDR_W-1:0]  addr;
        logic [ENTRY_W-1:0] data;
    } wr_rec_t;

    stage_t  s0;        // Entering
    stage_t  s1;        // RAM read in flight
    stage_t  s2;        // Read data here, write out
    wr_rec_t wr_now;    // Write of this cycle
    wr_rec_t wr1;       // Write one cycle back
    wr_rec_t wr2;       // Write two cycles back
    logic [ENTRY_W-1:0] old_entry;

    // Read issued straight away
    assign ram_addr = pixel_addr;

    // Gate sampled on entry, not at write time
    assign s0.valid = pixel.valid && calibration_on;
    assign s0.addr  = pixel_addr;
    assign s0.lit   = (pixel.luma > LUMA_THRESHOLD); // Strictly above

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1  <= '0;
            s2  <= '0;
            wr1 <= '0;
            wr2 <= '0;
        end else begin
            s1  <= s0;
            s2  <= s1;
            wr1 <= wr_now;
            wr2 <= wr1;
        end
    end

    // RAM data misses the two writes made since the read was issued
    always_comb begin
        if (wr1.valid && (wr1.addr == s2.addr)) begin
            old_entry = wr1.data;    // Newest wins
        end else if (wr2.valid && (wr2.addr == s2.addr)) begin
            old_entry = wr2.data;
        end else begin
            old_entry = ram_rdata;
        end
    end

    // Shift in the new plane at bit 0
    assign ram_we    = s2.valid;
    assign ram_waddr = s2.addr;
    assign ram_wdata = (old_entry << 1) | ENTRY_W'(s2.lit);

    assign wr_now.valid = ram_we;
    assign wr_now.addr  = s2.addr;
    assign wr_now.data  = ram_wdata;

    // Every table write traces back to a gated pixel two cycles earlier
    a_write_from_pixel: assert property (
        @(posedge clk) disable iff (!arst_n)
        ram_we |-> ($past(pixel.valid, 2) && $past(calibration_on, 2))
    );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the calibration testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_calibration_manager
BUILD_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

if ! command -v verilator > /dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing --assert --top-module "$TOP" \
    -Mdir "$BUILD_DIR" -f list.f > "$BUILD_LOG" 2>&1
build_status=$?
if [ "$build_status" -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Build failed with status $build_status"
    exit 1
fi

"./$BUILD_DIR/V$TOP" > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"

if grep -q "test failed" "$SIM_LOG"; then
    echo "Simulation reported failure"
    exit 1
fi
if [ "$sim_status" -ne 0 ] || ! grep -q "test passed" "$SIM_LOG"; then
    echo "Simulation ended abnormally with status $sim_status"
    exit 1
fi
echo "Simulation passed"
exit 0

// ==== tb_calibration_manager.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_calibration_manager;

    import led_pkg::*;
    import cal_pkg::*;

    localparam int NUM_LEDS          = 12;
    localparam int LED_ADDRESS_WIDTH = 3;
    localparam int NUM_PIXELS        = 16;
    localparam logic [LUMA_WIDTH-1:0] LUMA_THRESHOLD = 16'h8000;
    localparam int CREDIT_DEPTH      = 4;
    localparam int ADDR_W            = $clog2(NUM_PIXELS);
    localparam int ENTRY_W           = LED_ADDRESS_WIDTH + 1;
    localparam int NUM_PLANES        = LED_ADDRESS_WIDTH + 1;  // Bit-planes before wrap

    localparam int RESET_CYCLES   = 8;
    localparam int RUN_CYCLES     = 1000;   // Random stimulus phase
    localparam int DRAIN_CYCLES   = 4;      // Pipeline holds up to three pixels
    localparam int READ_CYCLES    = NUM_PIXELS + 2;
    localparam int TOTAL_CYCLES   = RESET_CYCLES + 1 + RUN_CYCLES + DRAIN_CYCLES + READ_CYCLES;
    localparam int TIMEOUT_CYCLES = 4 * TOTAL_CYCLES;

    logic               clk = 1'b0;
    logic               arst_n;
    logic               increment_id;
    logic               calibration_on;
    logic               led_credit;
    rgb_t               led_color;
    logic               color_valid;
    logic               displayed_frame_valid;
    logic  [ADDR_W-1:0] pixel_addr;
    frame_pixel_t       pixel;
    logic  [ADDR_W-1:0] cal_read_addr;
    logic [ENTRY_W-1:0] cal_read_data;

    // Reference model state
    logic [ENTRY_W-1:0] model_table [NUM_PIXELS];
    shower_state_e      model_state;
    int                 model_credits;   // Stored credits
    int                 model_led;       // Next LED to send
    int                 model_pending;   // Plane for the next frame
    int                 model_active;    // Plane of this frame
    int                 frames_done;
    logic  [ADDR_W-1:0] prev_addr1;      // Address one cycle back
    logic  [ADDR_W-1:0] prev_addr2;      // Two cycles back
    integer             seed;

    calibration_manager #(
        .NUM_LEDS          (NUM_LEDS),
        .LED_ADDRESS_WIDTH (LED_ADDRESS_WIDTH),
        .NUM_PIXELS        (NUM_PIXELS),
        .LUMA_THRESHOLD    (LUMA_THRESHOLD),
        .CREDIT_DEPTH      (CREDIT_DEPTH)
    ) DUT (
        .clk                   (clk),
        .arst_n                (arst_n),
        .increment_id          (increment_id),
        .calibration_on        (calibration_on),
        .led_credit            (led_credit),
        .led_color             (led_color),
        .color_valid           (color_valid),
        .displayed_frame_valid (displayed_frame_valid),
        .pixel_addr            (pixel_addr),
        .pixel                 (pixel),
        .cal_read_addr         (cal_read_addr),
        .cal_read_data         (cal_read_data)
    );

    always #4 clk = ~clk;  // 8 ns period

    // LED lit on every channel when its plane bit is set
    function automatic rgb_t plane_color(input int led, input int plane);
        rgb_t c;
        logic on;
        on = ((led >> plane) & 1) != 0;
        c.green = on ? 8'hFF : 8'h00;
        c.red   = on ? 8'hFF : 8'h00;
        c.blue  = on ? 8'hFF : 8'h00;
        return c;
    endfunction

    // Newest plane enters at bit 0, oldest falls off the top
    function automatic logic [ENTRY_W-1:0] shift_in(input logic [ENTRY_W-1:0] old,
                                                   input logic lit);
        return {old[ENTRY_W-2:0], lit};
    endfunction

    // Model's view of whether a colour word goes out this cycle
    function automatic logic model_sends();
        return (model_state == SH_SEND) && (model_credits != 0);
    endfunction

    task automatic check_value(input string test, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("mismatch %s expected %0h actual %0h", test, expected, actual);
            $display("test failed");
            $fatal(1, "Stopped at first error");
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            $display("%s", what);
            $display("test failed");
            $fatal(1, "Stopped at first error");
        end
    endtask

    task automatic check_shower();
        logic exp_valid;
        logic exp_frame;
        rgb_t exp_color;
        exp_valid = model_sends();
        exp_frame = exp_valid && (model_led == NUM_LEDS - 1);  // Last LED marks the frame
        exp_color = plane_color(model_led, model_active);
        if (color_valid) begin
            check_true(model_credits > 0, "colour word sent while no credit was stored");
        end
        check_value("credit pacing", 32'(exp_valid), 32'(color_valid));
        check_value("frame marking", 32'(exp_frame), 32'(displayed_frame_valid));
        if (exp_valid) begin
            check_value($sformatf("led colour led %0d plane %0d", model_led, model_active),
                        32'(exp_color), 32'(led_color));
        end
    endtask

    task automatic drive_random();
        logic [31:0] ctl;
        logic [31:0] lum;
        int          room;
        ctl  = $random(seed);
        lum  = $random(seed);
        room = CREDIT_DEPTH - model_credits + int'(model_sends());  // Never overfill driver
        led_credit   = ctl[0] && (room > 0);
        increment_id = (ctl[7:4] == 4'h0);
        case (ctl[9:8])
            2'd0:    pixel_addr = prev_addr1;  // Back-to-back repeat
            2'd1:    pixel_addr = prev_addr2;  // One-apart repeat
            default: pixel_addr = ctl[10 +: ADDR_W];
        endcase
        prev_addr2     = prev_addr1;
        prev_addr1     = pixel_addr;
        pixel.valid    = (ctl[15:14] != 2'b00);
        calibration_on = (ctl[17:16] != 2'b00);
        pixel.luma     = lum[15:0];
    endtask

    // Advance the model over the coming clock edge
    task automatic step_model();
        int   credits_before;
        logic sends;
        credits_before = model_credits;
        sends          = model_sends();
        model_credits  = model_credits + int'(led_credit) - int'(sends);
        case (model_state)
            SH_IDLE: begin
                if ((credits_before != 0) || led_credit) begin
                    model_state = SH_SEND;
                end
            end
            SH_SEND: begin
                if (sends && (model_led == NUM_LEDS - 1)) begin
                    model_led   = 0;
                    model_state = SH_DONE;
                    frames_done = frames_done + 1;
                end else if (sends) begin
                    model_led = model_led + 1;
                end
            end
            SH_DONE: begin
                model_active = model_pending;  // Pulse in this cycle counts later
                model_state  = SH_IDLE;
            end
            default: model_state = SH_IDLE;
        endcase
        if (increment_id) begin
            model_pending = (model_pending + 1) % NUM_PLANES;
        end
        if (pixel.valid && calibration_on) begin
            model_table[pixel_addr] = shift_in(model_table[pixel_addr],
                                               pixel.luma > LUMA_THRESHOLD);
        end
    endtask

    initial begin
        seed           = 22300;
        arst_n         = 1'b0;
        increment_id   = 1'b0;
        calibration_on = 1'b0;
        led_credit     = 1'b0;
        pixel_addr     = '0;
        pixel          = '0;
        cal_read_addr  = '0;
        prev_addr1     = '0;
        prev_addr2     = '0;
        model_state    = SH_IDLE;
        model_credits  = 0;
        model_led      = 0;
        model_pending  = 0;
        model_active   = 0;
        frames_done    = 0;
        for (int i = 0; i < NUM_PIXELS; i++) begin
            model_table[ADDR_W'(i)] = '0;  // RAM powers up empty
        end

        repeat (RESET_CYCLES) begin
            @(posedge clk);
            #1;
            check_value("reset", 32'd0, 32'(color_valid));
            check_value("reset", 32'd0, 32'(displayed_frame_valid));
        end
        arst_n = 1'b1;
        @(posedge clk);
        #1;
        check_value("reset", 32'd0, 32'(color_valid));  // First cycle out of reset
        check_value("reset", 32'd0, 32'(displayed_frame_valid));

        // Shower and pixel stream run side by side
        for (int i = 0; i < RUN_CYCLES; i++) begin
            check_shower();
            drive_random();
            step_model();
            @(posedge clk);
            #1;
        end

        led_credit     = 1'b0;
        increment_id   = 1'b0;
        calibration_on = 1'b0;
        pixel.valid    = 1'b0;
        repeat (DRAIN_CYCLES) @(posedge clk);
        #1;

        // Address in cycle t, data in cycle t+2
        for (int i = 0; i < READ_CYCLES; i++) begin
            if (i >= 2) begin
                check_value($sformatf("table readback addr %0d", i - 2),
                            32'(model_table[ADDR_W'(i - 2)]), 32'(cal_read_data));
            end
            if (i < NUM_PIXELS) begin
                cal_read_addr = ADDR_W'(i);
            end
            @(posedge clk);
            #1;
        end

        check_true(frames_done >= 4, "too few LED frames completed during the run");
        $display("test passed");
        $finish;
    end

    // Watchdog
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout after %0d cycles, the run did not finish", TIMEOUT_CYCLES);
        $display("test failed");
        $fatal(1, "Watchdog expired");
    end

endmodule

`default_nettype wire
